//--- rtl/ooo_hazard_params.svh
`ifndef OOO_HAZARD_PARAMS_SVH
`define OOO_HAZARD_PARAMS_SVH

// architectural integer registers, x0 included
`define NUM_REGS 32

// completion buffer entries
// must stay a power of two so the pointers wrap on their own
`define CB_DEPTH 8

// log2 of the buffer depth
`define CB_IDX_W 3

`endif

//--- rtl/ooo_hazard_pkg.sv
`include "ooo_hazard_params.svh"

package ooo_hazard_pkg;

  // register number, x0 to x31
  typedef logic [$clog2(`NUM_REGS)-1:0] reg_idx_t;

  // completion buffer tag
  typedef logic [`CB_IDX_W-1:0] cb_idx_t;

  // occupancy count, one bit wider so a full buffer fits
  typedef logic [`CB_IDX_W:0] cb_cnt_t;

  // exception cause, zero means no exception
  typedef logic [3:0] exc_code_t;

  // functional unit class of a decoded instruction
  typedef enum logic [1:0] {
    ARITH_S,
    MUL_S,
    DIV_S,
    LOADSTORE_S
  } fu_type_e;

  // operand source, only the two register selects read the register file
  typedef enum logic [1:0] {
    SRC_REG0,
    SRC_REG1,
    SRC_IMM,
    SRC_PC
  } src_sel_e;

  // decoded instruction offered for dispatch
  typedef struct packed {
    logic     valid;
    fu_type_e fu_type;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    logic     wen;
    src_sel_e source_a_sel;
    src_sel_e source_b_sel;
  } dispatch_req_t;

  // one functional unit result
  typedef struct packed {
    logic      valid;
    cb_idx_t   idx;
    exc_code_t exc;
    logic      mispredict;
  } writeback_t;

  // one retired entry
  typedef struct packed {
    logic     valid;
    cb_idx_t  idx;
    reg_idx_t rd;
    logic     wen;
    logic     mispredict;
  } commit_t;

  // privilege handshake states
  typedef enum logic [1:0] {
    LINK_IDLE,
    LINK_REQ,
    LINK_RELEASE
  } link_state_e;

endpackage

//--- rtl/reg_busy_scoreboard.sv
`timescale 1ns/1ps

`include "ooo_hazard_params.svh"

module reg_busy_scoreboard (
  input  logic                          CLK,
  input  logic                          reset,
  input  ooo_hazard_pkg::dispatch_req_t dispatch,
  input  logic                          dispatch_fire,
  input  ooo_hazard_pkg::commit_t       commit,
  input  logic                          flush,
  output logic                          rs1_busy,
  output logic                          rs2_busy,
  output logic                          rd_busy
);

  // one bit per architectural register, bit 0 never set
  logic [`NUM_REGS-1:0] busy;
  logic [`NUM_REGS-1:0] set_mask;
  logic [`NUM_REGS-1:0] clr_mask;

  // decode the set and clear requests of this cycle
  always_comb begin
    set_mask = '0;
    clr_mask = '0;
    // dispatch of a writer claims its destination
    if (dispatch_fire && dispatch.wen && (dispatch.rd != '0)) begin
      set_mask[dispatch.rd] = 1'b1;
    end
    // retiring writer releases it again
    if (commit.valid && commit.wen && (commit.rd != '0)) begin
      clr_mask[commit.rd] = 1'b1;
    end
  end

  // the WAW stall keeps set and clear off the same register,
  // so the order of the two masks does not matter
  always_ff @(posedge CLK) begin
    if (reset || flush) begin
      busy <= '0;
    end else begin
      busy <= (busy & ~clr_mask) | set_mask;
    end
  end

  // lookups for the instruction waiting at dispatch
  assign rs1_busy = busy[dispatch.rs1];
  assign rs2_busy = busy[dispatch.rs2];
  assign rd_busy  = busy[dispatch.rd];

  // a retiring writer must own the bit it clears
  a_commit_clears_set_bit: assert property (
    @(posedge CLK) disable iff (reset)
    (commit.valid && commit.wen && (commit.rd != '0)) |-> busy[commit.rd]
  );

endmodule

//--- rtl/completion_buffer.sv
`timescale 1ns/1ps

`include "ooo_hazard_params.svh"

module completion_buffer (
  input  logic                          CLK,
  input  logic                          reset,
  input  ooo_hazard_pkg::dispatch_req_t dispatch,
  input  logic                          dispatch_fire,
  output ooo_hazard_pkg::cb_idx_t       dispatch_idx,
  input  ooo_hazard_pkg::writeback_t    wb,
  input  logic                          flush,
  output logic                          cb_full,
  output ooo_hazard_pkg::commit_t       commit,
  output logic                          head_exc_valid,
  output ooo_hazard_pkg::exc_code_t     head_exc,
  output ooo_hazard_pkg::cb_idx_t       head_idx
);
  import ooo_hazard_pkg::*;

  // ring pointers and occupancy
  cb_idx_t head;
  cb_idx_t tail;
  cb_cnt_t count;

  // per-entry state
  logic [`CB_DEPTH-1:0] ent_done;
  reg_idx_t             ent_rd         [`CB_DEPTH];
  logic                 ent_wen        [`CB_DEPTH];
  exc_code_t            ent_exc        [`CB_DEPTH];
  logic                 ent_mispredict [`CB_DEPTH];

  logic    cb_empty;
  logic    alloc;
  logic    retire;
  cb_idx_t wb_offset;

  // commit register
  logic     commit_valid_q;
  cb_idx_t  commit_idx_q;
  reg_idx_t commit_rd_q;
  logic     commit_wen_q;
  logic     commit_mispredict_q;

  assign cb_empty = (count == '0);
  assign cb_full  = (count == cb_cnt_t'(`CB_DEPTH));

  // a flush squashes everything in flight, including this cycle's requests
  assign alloc  = dispatch_fire & ~flush;
  assign retire = ~cb_empty & ent_done[head] & (ent_exc[head] == '0) & ~flush;

  // head finished with a fault, handed to the privilege link
  assign head_exc_valid = ~cb_empty & ent_done[head] & (ent_exc[head] != '0) & ~flush;
  assign head_exc       = ent_exc[head];
  assign head_idx       = head;

  // new entry is tagged with the tail slot
  assign dispatch_idx = tail;

  // distance of a writeback tag from the head, for the occupancy check
  assign wb_offset = wb.idx - head;

  always_ff @(posedge CLK) begin
    if (reset || flush) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (alloc) begin
        tail <= tail + 1'b1;
      end
      if (retire) begin
        head <= head + 1'b1;
      end
      count <= count + cb_cnt_t'(alloc) - cb_cnt_t'(retire);
    end
  end

  // done flags, free slots always read zero
  always_ff @(posedge CLK) begin
    if (reset || flush) begin
      ent_done <= '0;
    end else begin
      if (retire) begin
        ent_done[head] <= 1'b0;
      end
      if (wb.valid) begin
        ent_done[wb.idx] <= 1'b1;
      end
    end
  end

  // entry payload
  always_ff @(posedge CLK) begin
    if (alloc) begin
      ent_rd[tail]  <= dispatch.rd;
      ent_wen[tail] <= dispatch.wen;
    end
    if (wb.valid) begin
      ent_exc[wb.idx]        <= wb.exc;
      ent_mispredict[wb.idx] <= wb.mispredict;
    end
  end

  // in-order retire, one entry per cycle
  always_ff @(posedge CLK) begin
    if (reset || flush) begin
      commit_valid_q <= 1'b0;
    end else begin
      commit_valid_q <= retire;
    end
  end

  always_ff @(posedge CLK) begin
    if (retire) begin
      commit_idx_q        <= head;
      commit_rd_q         <= ent_rd[head];
      commit_wen_q        <= ent_wen[head];
      commit_mispredict_q <= ent_mispredict[head];
    end
  end

  assign commit = '{valid:      commit_valid_q,
                    idx:        commit_idx_q,
                    rd:         commit_rd_q,
                    wen:        commit_wen_q,
                    mispredict: commit_mispredict_q};

  // writeback only for an occupied slot that has not finished yet
  a_wb_to_pending_entry: assert property (
    @(posedge CLK) disable iff (reset || flush)
    wb.valid |-> ((cb_cnt_t'(wb_offset) < count) && !ent_done[wb.idx])
  );

  // the hazard unit must hold dispatch while the ring is full
  a_no_alloc_when_full: assert property (
    @(posedge CLK) disable iff (reset)
    dispatch_fire |-> !cb_full
  );

endmodule

//--- rtl/ooo_hazard_unit.sv
`timescale 1ns/1ps

module ooo_hazard_unit (
  input  ooo_hazard_pkg::dispatch_req_t dispatch,
  input  logic                          rs1_busy,
  input  logic                          rs2_busy,
  input  logic                          rd_busy,
  input  logic                          cb_full,
  input  logic                          busy_du,
  input  logic                          busy_ls,
  input  logic                          link_busy,
  input  logic                          commit_mispredict,
  output logic                          dispatch_fire,
  output logic                          pc_en,
  output logic                          fetch_decode_flush
);
  import ooo_hazard_pkg::*;

  logic src_a_reads;
  logic src_b_reads;
  logic raw_hazard;
  logic waw_hazard;
  logic unit_hazard;
  logic resource_hazard;
  logic stall;

  // operand a reads rs1 only for a register select
  always_comb begin
    case (dispatch.source_a_sel)
      SRC_REG0, SRC_REG1: src_a_reads = 1'b1;
      default:            src_a_reads = 1'b0;
    endcase
  end

  // operand b reads rs2 the same way
  always_comb begin
    case (dispatch.source_b_sel)
      SRC_REG0, SRC_REG1: src_b_reads = 1'b1;
      default:            src_b_reads = 1'b0;
    endcase
  end

  // RAW, ignored for immediate and pc operands
  assign raw_hazard = (src_a_reads & rs1_busy) | (src_b_reads & rs2_busy);

  // WAW, only when the instruction writes back
  assign waw_hazard = dispatch.wen & rd_busy;

  // divider and load/store unit block only their own class
  // arith and mul are fully pipelined here
  always_comb begin
    case (dispatch.fu_type)
      DIV_S:       unit_hazard = busy_du;
      LOADSTORE_S: unit_hazard = busy_ls;
      default:     unit_hazard = 1'b0;
    endcase
  end

  // no free tag, or an exception handoff in progress
  assign resource_hazard = cb_full | link_busy;

  assign stall = raw_hazard | waw_hazard | unit_hazard | resource_hazard;

  // mispredicted branch at commit redirects the front end
  // interrupt, ifence and csr flush sources are not in this slice
  assign fetch_decode_flush = commit_mispredict;

  // flush wins over everything else and kills the dispatch
  assign dispatch_fire = dispatch.valid & ~stall & ~fetch_decode_flush;

  // fetch holds while a valid instruction waits on a hazard
  // the redirect always lets the pc move
  assign pc_en = fetch_decode_flush | ~(dispatch.valid & stall);

endmodule

//--- rtl/prv_exception_link.sv
`timescale 1ns/1ps

module prv_exception_link (
  input  logic                      CLK,
  input  logic                      reset,
  input  logic                      head_exc_valid,
  input  ooo_hazard_pkg::exc_code_t head_exc,
  input  ooo_hazard_pkg::cb_idx_t   head_idx,
  output logic                      prv_req,
  output ooo_hazard_pkg::exc_code_t exc_cause,
  output ooo_hazard_pkg::cb_idx_t   epc_idx,
  input  logic                      prv_ack,
  output logic                      link_busy,
  output logic                      flush_all
);
  import ooo_hazard_pkg::*;

  link_state_e state;
  link_state_e state_next;

  // cause and tag held for the whole handshake
  exc_code_t cause_q;
  cb_idx_t   idx_q;

  always_ff @(posedge CLK) begin
    if (reset) begin
      state <= LINK_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // four-phase: req up, ack up, req down, ack down
  always_comb begin
    state_next = state;
    case (state)
      LINK_IDLE:    if (head_exc_valid) state_next = LINK_REQ;
      LINK_REQ:     if (prv_ack) state_next = LINK_RELEASE;
      LINK_RELEASE: if (!prv_ack) state_next = LINK_IDLE;
      default:      state_next = LINK_IDLE;
    endcase
  end

  // latch the faulting head when the handoff starts
  always_ff @(posedge CLK) begin
    if ((state == LINK_IDLE) && head_exc_valid) begin
      cause_q <= head_exc;
      idx_q   <= head_idx;
    end
  end

  assign prv_req   = (state == LINK_REQ);
  assign exc_cause = cause_q;
  assign epc_idx   = idx_q;

  // dispatch stays frozen until the privilege block has let go
  assign link_busy = (state != LINK_IDLE);

  // single cycle, the state leaves LINK_REQ on the same edge
  assign flush_all = (state == LINK_REQ) & prv_ack;

  // payload must not move while the privilege block may still sample it
  a_cause_stable_until_ack: assert property (
    @(posedge CLK) disable iff (reset)
    (prv_req && !prv_ack) |=> ($stable(exc_cause) && $stable(epc_idx) && prv_req)
  );

endmodule

//--- rtl/ooo_issue_control_top.sv
`timescale 1ns/1ps

module ooo_issue_control_top (
  input  logic                          CLK,
  input  logic                          reset,
  input  ooo_hazard_pkg::dispatch_req_t dispatch,
  input  ooo_hazard_pkg::writeback_t    wb,
  input  logic                          busy_du,
  input  logic                          busy_ls,
  output logic                          pc_en,
  output logic                          dispatch_fire,
  output ooo_hazard_pkg::cb_idx_t       dispatch_idx,
  output logic                          fetch_decode_flush,
  output ooo_hazard_pkg::commit_t       commit,
  output logic                          prv_req,
  output ooo_hazard_pkg::exc_code_t     exc_cause,
  output ooo_hazard_pkg::cb_idx_t       epc_idx,
  input  logic                          prv_ack
);
  import ooo_hazard_pkg::*;

  logic      rs1_busy;
  logic      rs2_busy;
  logic      rd_busy;
  logic      cb_full;
  logic      link_busy;
  logic      flush_all;
  logic      commit_mispredict;
  logic      flush;
  logic      head_exc_valid;
  exc_code_t head_exc;
  cb_idx_t   head_idx;

  // a branch that retires mispredicted squashes everything younger
  assign commit_mispredict = commit.valid & commit.mispredict;
  assign flush             = flush_all | commit_mispredict;

  ooo_hazard_unit u_hazard (
    .dispatch           (dispatch),
    .rs1_busy           (rs1_busy),
    .rs2_busy           (rs2_busy),
    .rd_busy            (rd_busy),
    .cb_full            (cb_full),
    .busy_du            (busy_du),
    .busy_ls            (busy_ls),
    .link_busy          (link_busy),
    .commit_mispredict  (commit_mispredict),
    .dispatch_fire      (dispatch_fire),
    .pc_en              (pc_en),
    .fetch_decode_flush (fetch_decode_flush)
  );

  reg_busy_scoreboard u_scoreboard (
    .CLK           (CLK),
    .reset         (reset),
    .dispatch      (dispatch),
    .dispatch_fire (dispatch_fire),
    .commit        (commit),
    .flush         (flush),
    .rs1_busy      (rs1_busy),
    .rs2_busy      (rs2_busy),
    .rd_busy       (rd_busy)
  );

  completion_buffer u_cbuf (
    .CLK            (CLK),
    .reset          (reset),
    .dispatch       (dispatch),
    .dispatch_fire  (dispatch_fire),
    .dispatch_idx   (dispatch_idx),
    .wb             (wb),
    .flush          (flush),
    .cb_full        (cb_full),
    .commit         (commit),
    .head_exc_valid (head_exc_valid),
    .head_exc       (head_exc),
    .head_idx       (head_idx)
  );

  prv_exception_link u_prv_link (
    .CLK            (CLK),
    .reset          (reset),
    .head_exc_valid (head_exc_valid),
    .head_exc       (head_exc),
    .head_idx       (head_idx),
    .prv_req        (prv_req),
    .exc_cause      (exc_cause),
    .epc_idx        (epc_idx),
    .prv_ack        (prv_ack),
    .link_busy      (link_busy),
    .flush_all      (flush_all)
  );

endmodule

//--- sim/ooo_issue_checker.sv
`timescale 1ns/1ps

`include "ooo_hazard_params.svh"

module ooo_issue_checker (
  input  logic                          CLK,
  input  logic                          reset,
  input  ooo_hazard_pkg::dispatch_req_t dispatch,
  input  ooo_hazard_pkg::writeback_t    wb,
  input  logic                          busy_du,
  input  logic                          busy_ls,
  input  logic                          prv_ack,
  input  logic                          pc_en,
  input  logic                          dispatch_fire,
  input  ooo_hazard_pkg::cb_idx_t       dispatch_idx,
  input  logic                          fetch_decode_flush,
  input  ooo_hazard_pkg::commit_t       commit,
  input  logic                          prv_req,
  input  ooo_hazard_pkg::exc_code_t     exc_cause,
  input  ooo_hazard_pkg::cb_idx_t       epc_idx,
  input  logic                          end_of_test,
  output logic                          model_idle,
  output logic                          report_done,
  output int                            fail_count
);
  import ooo_hazard_pkg::*;

  // one in-flight instruction as the model sees it
  typedef struct packed {
    cb_idx_t   tag;
    reg_idx_t  rd;
    logic      wen;
    logic      done;
    exc_code_t exc;
    logic      mispredict;
  } entry_t;

  string test_name [1:5];
  int    errors    [1:5];
  int    checks    [1:5];
  int    events    [1:5];

  // reference state
  logic [`NUM_REGS-1:0] busy_m;
  entry_t               q [$];
  cb_idx_t              tail_m;
  logic                 cv_m;
  entry_t               c_m;
  link_state_e          link_m;
  exc_code_t            cause_m;
  cb_idx_t              epc_m;

  // bookkeeping for the reset and handoff tests
  int                   t1_state;
  logic                 post_trap;
  logic                 reuse_watch;
  logic [`NUM_REGS-1:0] busy_at_trap;

  initial begin
    test_name[1] = "reset_state";
    test_name[2] = "dispatch_stall_rule";
    test_name[3] = "in_order_commit";
    test_name[4] = "exception_handshake";
    test_name[5] = "mispredict_flush";
    foreach (errors[t]) begin
      errors[t] = 0;
      checks[t] = 0;
      events[t] = 0;
    end
    model_idle  = 1'b1;
    report_done = 1'b0;
    fail_count  = 0;
    t1_state    = 0;
  end

  task automatic value_error(input int t, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
    errors[t]++;
    $display("[FAIL] %s %s expected %0h actual %0h at %0t",
             test_name[t], what, exp, act, $time);
  endtask

  task automatic plain_error(input int t, input string msg);
    errors[t]++;
    $display("error in %s at %0t: %s", test_name[t], $time, msg);
  endtask

  task automatic expect_eq(input int t, input string what,
                           input logic [31:0] exp, input logic [31:0] act);
    checks[t]++;
    if (exp !== act) begin
      value_error(t, what, exp, act);
    end
  endtask

  task automatic print_test_line(input int t);
    $display("test %0d %s: %0d checks, %0d events, %0d errors, %s", t, test_name[t],
             checks[t], events[t], errors[t], (errors[t] == 0) ? "passed" : "failed");
  endtask

  // the DUT clears everything on a reset edge
  task automatic clear_model();
    busy_m      = '0;
    q.delete();
    tail_m      = '0;
    cv_m        = 1'b0;
    link_m      = LINK_IDLE;
    post_trap   = 1'b0;
    reuse_watch = 1'b0;
    t1_state    = 0;
    model_idle  = 1'b1;
  endtask

  // compare one cycle, then advance the model across the edge
  task automatic step_model();
    logic   reads_a;
    logic   reads_b;
    logic   unit_blk;
    logic   stall;
    logic   fdf_m;
    logic   fire_m;
    logic   flush_all_m;
    logic   flush_m;
    logic   head_done;
    logic   retire_m;
    logic   hexc_m;
    logic   found;
    entry_t e;

    // stall rule straight from the hazard definition
    reads_a  = (dispatch.source_a_sel == SRC_REG0) || (dispatch.source_a_sel == SRC_REG1);
    reads_b  = (dispatch.source_b_sel == SRC_REG0) || (dispatch.source_b_sel == SRC_REG1);
    unit_blk = ((dispatch.fu_type == DIV_S) && busy_du) ||
               ((dispatch.fu_type == LOADSTORE_S) && busy_ls);
    stall    = (reads_a && busy_m[dispatch.rs1]) || (reads_b && busy_m[dispatch.rs2]) ||
               (dispatch.wen && busy_m[dispatch.rd]) || unit_blk ||
               (q.size() == `CB_DEPTH) || (link_m != LINK_IDLE);
    fdf_m       = cv_m && c_m.mispredict;
    fire_m      = dispatch.valid && !stall && !fdf_m;
    flush_all_m = (link_m == LINK_REQ) && prv_ack;
    flush_m     = flush_all_m || fdf_m;
    head_done   = (q.size() != 0) && q[0].done;
    retire_m    = head_done && (q[0].exc == '0) && !flush_m;
    hexc_m      = head_done && (q[0].exc != '0) && !flush_m;

    // quiet outputs right after reset, then the first dispatch gets tag zero
    if (t1_state == 0) begin
      expect_eq(1, "commit.valid", 0, commit.valid);
      expect_eq(1, "prv_req", 0, prv_req);
      expect_eq(1, "fetch_decode_flush", 0, fetch_decode_flush);
      expect_eq(1, "dispatch_fire", 0, dispatch_fire);
      expect_eq(1, "pc_en", 1, pc_en);
      t1_state = 1;
    end else if ((t1_state == 1) && dispatch.valid && !unit_blk) begin
      expect_eq(1, "dispatch_fire", 1, dispatch_fire);
      expect_eq(1, "dispatch_idx", 0, dispatch_idx);
      events[1]++;
      t1_state = 2;
      print_test_line(1);
    end

    // fire decision every cycle
    expect_eq(2, "dispatch_fire", fire_m, dispatch_fire);
    expect_eq(2, "pc_en", fdf_m || !(dispatch.valid && stall), pc_en);
    if (fire_m && dispatch_fire) begin
      expect_eq(2, "dispatch_idx", tail_m, dispatch_idx);
      events[2]++;
    end

    // retire order and payload
    expect_eq(3, "commit.valid", cv_m, commit.valid);
    if (cv_m && commit.valid) begin
      expect_eq(3, "commit.idx", c_m.tag, commit.idx);
      expect_eq(3, "commit.rd", c_m.rd, commit.rd);
      expect_eq(3, "commit.wen", c_m.wen, commit.wen);
      expect_eq(5, "commit.mispredict", c_m.mispredict, commit.mispredict);
    end

    // redirect comes with the mispredicting commit
    expect_eq(5, "fetch_decode_flush", fdf_m, fetch_decode_flush);
    if (fdf_m) begin
      events[5]++;
    end

    // privilege handoff
    expect_eq(4, "prv_req", link_m == LINK_REQ, prv_req);
    if ((link_m == LINK_REQ) && prv_req) begin
      expect_eq(4, "exc_cause", cause_m, exc_cause);
      expect_eq(4, "epc_idx", epc_m, epc_idx);
    end
    if ((link_m != LINK_IDLE) && (dispatch_fire || commit.valid)) begin
      plain_error(4, "a dispatch or a commit happened while the exception handoff was open");
    end
    // both sides must be empty one cycle after the flush
    if (post_trap) begin
      expect_eq(4, "dispatch_idx after flush", 0, dispatch_idx);
      expect_eq(4, "commit.valid after flush", 0, commit.valid);
      post_trap = 1'b0;
    end
    // first dispatch after the handoff, a register that was busy is free again
    if (reuse_watch && fire_m) begin
      if ((dispatch.wen && busy_at_trap[dispatch.rd]) ||
          (reads_a && busy_at_trap[dispatch.rs1]) ||
          (reads_b && busy_at_trap[dispatch.rs2])) begin
        expect_eq(4, "dispatch_fire on freed register", 1, dispatch_fire);
      end
      reuse_watch = 1'b0;
    end
    if (flush_all_m) begin
      events[4]++;
      busy_at_trap = busy_m;
      post_trap    = 1'b1;
      reuse_watch  = 1'b1;
    end

    // link state uses the head before any pop
    case (link_m)
      LINK_IDLE: begin
        if (hexc_m) begin
          link_m  = LINK_REQ;
          cause_m = q[0].exc;
          epc_m   = q[0].tag;
        end
      end
      LINK_REQ: begin
        if (prv_ack) begin
          link_m = LINK_RELEASE;
        end
      end
      default: begin
        if (!prv_ack) begin
          link_m = LINK_IDLE;
        end
      end
    endcase

    if (flush_m) begin
      busy_m = '0;
      q.delete();
      tail_m = '0;
      cv_m   = 1'b0;
    end else begin
      if (cv_m && c_m.wen && (c_m.rd != '0)) begin
        busy_m[c_m.rd] = 1'b0;
      end
      if (fire_m && dispatch.wen && (dispatch.rd != '0)) begin
        busy_m[dispatch.rd] = 1'b1;
      end
      cv_m = retire_m;
      if (retire_m) begin
        c_m = q.pop_front();
        events[3]++;
      end
      if (wb.valid) begin
        found = 1'b0;
        foreach (q[i]) begin
          if ((q[i].tag == wb.idx) && !q[i].done) begin
            q[i].done       = 1'b1;
            q[i].exc        = wb.exc;
            q[i].mispredict = wb.mispredict;
            found           = 1'b1;
          end
        end
        if (!found) begin
          plain_error(3, "a writeback named a tag that was not pending");
        end
      end
      if (fire_m) begin
        e = '{tag: tail_m, rd: dispatch.rd, wen: dispatch.wen,
              done: 1'b0, exc: '0, mispredict: 1'b0};
        q.push_back(e);
        tail_m = tail_m + 1'b1;
      end
    end
    model_idle = (q.size() == 0) && (link_m == LINK_IDLE) && !cv_m;
  endtask

  // sampled on the rising edge, where every DUT output has settled
  always @(posedge CLK) begin
    if (reset) begin
      clear_model();
    end else begin
      step_model();
    end
  end

  task automatic final_report();
    int total_checks;
    int total_errors;

    if (t1_state != 2) begin
      plain_error(1, "no valid dispatch was seen after reset");
      print_test_line(1);
    end
    if (events[3] == 0) begin
      plain_error(3, "no entry ever committed");
    end
    if (events[4] == 0) begin
      plain_error(4, "no exception handshake took place");
    end
    if (events[5] == 0) begin
      plain_error(5, "no mispredicted branch reached commit");
    end
    for (int t = 2; t <= 5; t++) begin
      print_test_line(t);
    end
    total_checks = 0;
    total_errors = 0;
    foreach (errors[t]) begin
      total_checks += checks[t];
      total_errors += errors[t];
    end
    $display("tests 5, checks %0d, errors %0d", total_checks, total_errors);
    fail_count  = total_errors;
    report_done = 1'b1;
  endtask

  always @(posedge end_of_test) begin
    final_report();
  end

endmodule

//--- sim/tb_ooo_issue_control.sv
`timescale 1ns/1ps

module tb_ooo_issue_control;
  import ooo_hazard_pkg::*;

  localparam int RESET_CYCLES   = 8;
  localparam int STIM_CYCLES    = 2000;
  // room for the drain, a last handoff and the report
  localparam int DRAIN_MARGIN   = 400;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + 2 + STIM_CYCLES + DRAIN_MARGIN;

  logic          CLK;
  logic          reset;
  dispatch_req_t dispatch;
  writeback_t    wb;
  logic          busy_du;
  logic          busy_ls;
  logic          prv_ack;
  logic          pc_en;
  logic          dispatch_fire;
  cb_idx_t       dispatch_idx;
  logic          fetch_decode_flush;
  commit_t       commit;
  logic          prv_req;
  exc_code_t     exc_cause;
  cb_idx_t       epc_idx;

  logic          end_of_test;
  logic          model_idle;
  logic          report_done;
  int            fail_count;

  // stimulus state
  logic [15:0]   lfsr_state;
  cb_idx_t       pending [$];
  logic          last_fire;
  logic          ack_armed;
  int            ack_delay;

  ooo_issue_control_top DUT (
    .CLK                (CLK),
    .reset              (reset),
    .dispatch           (dispatch),
    .wb                 (wb),
    .busy_du            (busy_du),
    .busy_ls            (busy_ls),
    .pc_en              (pc_en),
    .dispatch_fire      (dispatch_fire),
    .dispatch_idx       (dispatch_idx),
    .fetch_decode_flush (fetch_decode_flush),
    .commit             (commit),
    .prv_req            (prv_req),
    .exc_cause          (exc_cause),
    .epc_idx            (epc_idx),
    .prv_ack            (prv_ack)
  );

  ooo_issue_checker u_check (
    .CLK                (CLK),
    .reset              (reset),
    .dispatch           (dispatch),
    .wb                 (wb),
    .busy_du            (busy_du),
    .busy_ls            (busy_ls),
    .prv_ack            (prv_ack),
    .pc_en              (pc_en),
    .dispatch_fire      (dispatch_fire),
    .dispatch_idx       (dispatch_idx),
    .fetch_decode_flush (fetch_decode_flush),
    .commit             (commit),
    .prv_req            (prv_req),
    .exc_cause          (exc_cause),
    .epc_idx            (epc_idx),
    .end_of_test        (end_of_test),
    .model_idle         (model_idle),
    .report_done        (report_done),
    .fail_count         (fail_count)
  );

  // 100 ns period
  always #50 CLK = ~CLK;

  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // one LFSR step per bit handed out
  function automatic logic [15:0] draw_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[14:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // registers x0 to x7 only, so hazards come often
  function automatic dispatch_req_t random_dispatch();
    dispatch_req_t d;
    d.valid        = (draw_bits(2) != 0);
    d.fu_type      = fu_type_e'(draw_bits(2));
    d.rs1          = reg_idx_t'(draw_bits(3));
    d.rs2          = reg_idx_t'(draw_bits(3));
    d.rd           = reg_idx_t'(draw_bits(3));
    d.wen          = (draw_bits(2) != 0);
    d.source_a_sel = src_sel_e'(draw_bits(2));
    d.source_b_sel = src_sel_e'(draw_bits(2));
    return d;
  endfunction

  // privilege block side, ack 1 to 4 cycles after req, release after req drops
  task automatic respond_ack();
    if (prv_ack) begin
      if (!prv_req) begin
        prv_ack = 1'b0;
      end
    end else if (prv_req) begin
      if (!ack_armed) begin
        ack_delay = 1 + int'(draw_bits(2));
        ack_armed = 1'b1;
      end
      ack_delay = ack_delay - 1;
      if (ack_delay == 0) begin
        prv_ack   = 1'b1;
        ack_armed = 1'b0;
      end
    end
  endtask

  // everything driven on one falling edge
  task automatic drive_cycle(input logic stim_on);
    int pick;

    busy_du = (draw_bits(2) == 0);
    busy_ls = (draw_bits(2) == 0);
    // a stalled instruction stays put until it fires
    if (!(dispatch.valid && !last_fire)) begin
      dispatch = stim_on ? random_dispatch() : '0;
    end
    wb = '0;
    if ((pending.size() != 0) && draw_bits(1)) begin
      pick     = int'(draw_bits(3)) % pending.size();
      wb.valid = 1'b1;
      wb.idx   = pending[pick];
      // rare fault or mispredict
      if (draw_bits(5) == 0) begin
        wb.exc = exc_code_t'(draw_bits(3) + 16'd1);
      end else if (draw_bits(5) == 0) begin
        wb.mispredict = 1'b1;
      end
      pending.delete(pick);
    end
    respond_ack();
  endtask

  // tags that still wait for a writeback
  always @(posedge CLK) begin
    if (reset || fetch_decode_flush || (prv_req && prv_ack)) begin
      pending.delete();
    end else if (dispatch_fire) begin
      pending.push_back(dispatch_idx);
    end
    last_fire = dispatch_fire;
  end

  initial begin
    CLK         = 1'b0;
    reset       = 1'b1;
    dispatch    = '0;
    wb          = '0;
    busy_du     = 1'b0;
    busy_ls     = 1'b0;
    prv_ack     = 1'b0;
    end_of_test = 1'b0;
    lfsr_state  = 16'd25;
    last_fire   = 1'b0;
    ack_armed   = 1'b0;
    ack_delay   = 0;
    repeat (RESET_CYCLES) @(negedge CLK);
    reset = 1'b0;
    // two idle cycles for the post-reset check
    repeat (2) @(negedge CLK);
    for (int i = 0; i < STIM_CYCLES; i++) begin
      drive_cycle(1'b1);
      @(negedge CLK);
    end
    // no new work, finish what is in flight
    do begin
      drive_cycle(1'b0);
      @(negedge CLK);
    end while (dispatch.valid || (pending.size() != 0) || !model_idle || prv_req || prv_ack);
    end_of_test = 1'b1;
    wait (report_done);
    if (fail_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(TIMEOUT_CYCLES * 100);
    $display("timeout: the run did not drain within %0d cycles", TIMEOUT_CYCLES);
    $display("Something failed");
    $finish;
  end

endmodule

//--- sources.f
+incdir+rtl
rtl/ooo_hazard_pkg.sv
rtl/reg_busy_scoreboard.sv
rtl/completion_buffer.sv
rtl/ooo_hazard_unit.sv
rtl/prv_exception_link.sv
rtl/ooo_issue_control_top.sv
sim/ooo_issue_checker.sv
sim/tb_ooo_issue_control.sv

//--- Bender.yml
package:
  name: ooo_issue_control

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/ooo_hazard_pkg.sv
      - rtl/reg_busy_scoreboard.sv
      - rtl/completion_buffer.sv
      - rtl/ooo_hazard_unit.sv
      - rtl/prv_exception_link.sv
      - rtl/ooo_issue_control_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/ooo_issue_checker.sv
      - sim/tb_ooo_issue_control.sv
